// ==== design/div_cfg_pkg.sv ====
package div_cfg_pkg;

  // Operand and result width.
  localparam int DATA_W = 8;

  // Width of the request tag that is echoed with the result.
  localparam int TAG_W = 4;

  // Iteration counter width, large enough to hold DATA_W.
  localparam int CNT_W = 4;

endpackage

// ==== design/div_op_pkg.sv ====
package div_op_pkg;

  // Divide unit opcodes.
  typedef enum logic [1:0] {
    OP_DIVU = 2'd0,
    OP_REMU = 2'd1,
    OP_DIV  = 2'd2,
    OP_REM  = 2'd3
  } div_op_e;

  // Divider core sequencing.
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } core_state_e;

  // True for the two signed opcodes.
  function automatic logic is_signed(div_op_e op);
    return (op == OP_DIV) || (op == OP_REM);
  endfunction

  // True when the remainder is the requested result.
  function automatic logic wants_rem(div_op_e op);
    return (op == OP_REMU) || (op == OP_REM);
  endfunction

endpackage

// ==== design/div_operand_stage.sv ====
module div_operand_stage (
  input  logic                              i_clk,
  input  logic                              i_arst_n,
  input  logic                              i_cg,
  input  logic                              i_start,
  input  div_op_pkg::div_op_e               i_op,
  input  logic [div_cfg_pkg::DATA_W-1:0]    i_dividend,
  input  logic [div_cfg_pkg::DATA_W-1:0]    i_divisor,
  input  logic [div_cfg_pkg::TAG_W-1:0]     i_tag,
  input  logic                              i_result_done,
  output logic                              o_busy,
  output logic                              o_core_begin,
  output logic [div_cfg_pkg::DATA_W-1:0]    o_mag_dividend,
  output logic [div_cfg_pkg::DATA_W-1:0]    o_mag_divisor,
  output div_op_pkg::div_op_e               o_op,
  output logic                              o_neg_quot,
  output logic                              o_neg_rem,
  output logic                              o_div_zero,
  output logic [div_cfg_pkg::TAG_W-1:0]     o_tag
);

  logic                           busy_q;
  logic                           begin_q;
  logic                           accept;
  logic                           sgn;
  logic                           dvd_neg;
  logic                           dvs_neg;
  logic [div_cfg_pkg::DATA_W-1:0] dvd_mag;
  logic [div_cfg_pkg::DATA_W-1:0] dvs_mag;

  // Busy drops in the cycle where the result is presented.
  assign o_busy = busy_q && !i_result_done;
  assign accept = i_start && !o_busy;

  // Operand signs only matter for signed opcodes.
  assign sgn     = div_op_pkg::is_signed(i_op);
  assign dvd_neg = sgn && i_dividend[div_cfg_pkg::DATA_W-1];
  assign dvs_neg = sgn && i_divisor[div_cfg_pkg::DATA_W-1];

  // Most negative value maps onto its unsigned magnitude.
  assign dvd_mag = dvd_neg ? (~i_dividend + 1'b1) : i_dividend;
  assign dvs_mag = dvs_neg ? (~i_divisor + 1'b1) : i_divisor;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy_q  <= 1'b0;
      begin_q <= 1'b0;
    end else if (i_cg) begin
      begin_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (i_result_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Request payload, held until the next accepted start.
  always_ff @(posedge i_clk) begin
    if (i_cg && accept) begin
      o_op           <= i_op;
      o_tag          <= i_tag;
      o_mag_dividend <= dvd_mag;
      o_mag_divisor  <= dvs_mag;
      o_neg_quot     <= dvd_neg ^ dvs_neg;
      o_neg_rem      <= dvd_neg;
      o_div_zero     <= (i_divisor == '0);
    end
  end

  assign o_core_begin = begin_q;

endmodule

// ==== design/div_core.sv ====
module div_core (
  input  logic                              i_clk,
  input  logic                              i_arst_n,
  input  logic                              i_cg,
  input  logic                              i_begin,
  input  logic [div_cfg_pkg::DATA_W-1:0]    i_dividend,
  input  logic [div_cfg_pkg::DATA_W-1:0]    i_divisor,
  output logic                              o_done,
  output logic [div_cfg_pkg::DATA_W-1:0]    o_quotient,
  output logic [div_cfg_pkg::DATA_W-1:0]    o_remainder
);

  div_op_pkg::core_state_e          state_q;
  logic [div_cfg_pkg::CNT_W-1:0]    cnt_q;
  logic                             done_q;
  logic [div_cfg_pkg::DATA_W-1:0]   divisor_q;
  logic [2*div_cfg_pkg::DATA_W-1:0] qr_q;
  logic [div_cfg_pkg::DATA_W:0]     diff;
  logic                             last;

  // Counter reaches zero on this enabled edge.
  assign last = (state_q == div_op_pkg::ST_RUN) && (cnt_q == div_cfg_pkg::CNT_W'(1));

  // Trial subtraction of the divisor from the partial remainder.
  assign diff = qr_q[2*div_cfg_pkg::DATA_W-1:div_cfg_pkg::DATA_W-1] - {1'b0, divisor_q};

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= div_op_pkg::ST_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else if (i_cg) begin
      done_q <= last;
      if (i_begin) begin
        state_q <= div_op_pkg::ST_RUN;
        cnt_q   <= div_cfg_pkg::CNT_W'(div_cfg_pkg::DATA_W);
      end else if (state_q == div_op_pkg::ST_RUN) begin
        cnt_q <= cnt_q - 1'b1;
        if (last) begin
          state_q <= div_op_pkg::ST_IDLE;
        end
      end
    end
  end

  // Upper half holds the remainder, lower half collects quotient bits.
  always_ff @(posedge i_clk) begin
    if (i_cg) begin
      if (i_begin) begin
        qr_q      <= {{div_cfg_pkg::DATA_W{1'b0}}, i_dividend};
        divisor_q <= i_divisor;
      end else if (state_q == div_op_pkg::ST_RUN) begin
        if (diff[div_cfg_pkg::DATA_W]) begin
          qr_q <= qr_q << 1;
        end else begin
          qr_q <= {diff[div_cfg_pkg::DATA_W-1:0], qr_q[div_cfg_pkg::DATA_W-2:0], 1'b1};
        end
      end
    end
  end

  assign o_done      = done_q;
  assign o_remainder = qr_q[2*div_cfg_pkg::DATA_W-1:div_cfg_pkg::DATA_W];
  assign o_quotient  = qr_q[div_cfg_pkg::DATA_W-1:0];

endmodule

// ==== design/div_result_stage.sv ====
module div_result_stage (
  input  logic                              i_clk,
  input  logic                              i_arst_n,
  input  logic                              i_cg,
  input  logic                              i_core_done,
  input  logic [div_cfg_pkg::DATA_W-1:0]    i_quotient,
  input  logic [div_cfg_pkg::DATA_W-1:0]    i_remainder,
  input  div_op_pkg::div_op_e               i_op,
  input  logic                              i_neg_quot,
  input  logic                              i_neg_rem,
  input  logic                              i_div_zero,
  input  logic [div_cfg_pkg::TAG_W-1:0]     i_tag,
  output logic                              o_done,
  output logic [div_cfg_pkg::DATA_W-1:0]    o_result,
  output logic [div_cfg_pkg::TAG_W-1:0]     o_tag
);

  logic [div_cfg_pkg::DATA_W-1:0] quot_fix;
  logic [div_cfg_pkg::DATA_W-1:0] rem_fix;
  logic [div_cfg_pkg::DATA_W-1:0] result_d;

  // A zero divisor keeps the all-ones quotient unsigned.
  assign quot_fix = (i_neg_quot && !i_div_zero) ? (~i_quotient + 1'b1) : i_quotient;

  // Remainder follows the dividend sign.
  assign rem_fix = i_neg_rem ? (~i_remainder + 1'b1) : i_remainder;

  assign result_d = div_op_pkg::wants_rem(i_op) ? rem_fix : quot_fix;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_done   <= 1'b0;
      o_result <= '0;
      o_tag    <= '0;
    end else if (i_cg) begin
      o_done <= i_core_done;
      // Result holds until the next completion.
      if (i_core_done) begin
        o_result <= result_d;
        o_tag    <= i_tag;
      end
    end
  end

endmodule

// ==== design/div_unit.sv ====
module div_unit (
  input  logic                              i_clk,
  input  logic                              i_arst_n,
  input  logic                              i_cg,
  input  logic                              i_start,
  input  div_op_pkg::div_op_e               i_op,
  input  logic [div_cfg_pkg::DATA_W-1:0]    i_dividend,
  input  logic [div_cfg_pkg::DATA_W-1:0]    i_divisor,
  input  logic [div_cfg_pkg::TAG_W-1:0]     i_tag,
  output logic                              o_busy,
  output logic                              o_done,
  output logic [div_cfg_pkg::DATA_W-1:0]    o_result,
  output logic [div_cfg_pkg::TAG_W-1:0]     o_tag
);

  logic                           core_begin;
  logic                           core_done;
  logic                           result_done;
  logic [div_cfg_pkg::DATA_W-1:0] mag_dividend;
  logic [div_cfg_pkg::DATA_W-1:0] mag_divisor;
  logic [div_cfg_pkg::DATA_W-1:0] raw_quotient;
  logic [div_cfg_pkg::DATA_W-1:0] raw_remainder;
  div_op_pkg::div_op_e            op_q;
  logic                           neg_quot;
  logic                           neg_rem;
  logic                           div_zero;
  logic [div_cfg_pkg::TAG_W-1:0]  tag_q;

  div_operand_stage u_operand (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_cg           (i_cg),
    .i_start        (i_start),
    .i_op           (i_op),
    .i_dividend     (i_dividend),
    .i_divisor      (i_divisor),
    .i_tag          (i_tag),
    .i_result_done  (result_done),
    .o_busy         (o_busy),
    .o_core_begin   (core_begin),
    .o_mag_dividend (mag_dividend),
    .o_mag_divisor  (mag_divisor),
    .o_op           (op_q),
    .o_neg_quot     (neg_quot),
    .o_neg_rem      (neg_rem),
    .o_div_zero     (div_zero),
    .o_tag          (tag_q)
  );

  div_core u_core (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_cg        (i_cg),
    .i_begin     (core_begin),
    .i_dividend  (mag_dividend),
    .i_divisor   (mag_divisor),
    .o_done      (core_done),
    .o_quotient  (raw_quotient),
    .o_remainder (raw_remainder)
  );

  div_result_stage u_result (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_cg        (i_cg),
    .i_core_done (core_done),
    .i_quotient  (raw_quotient),
    .i_remainder (raw_remainder),
    .i_op        (op_q),
    .i_neg_quot  (neg_quot),
    .i_neg_rem   (neg_rem),
    .i_div_zero  (div_zero),
    .i_tag       (tag_q),
    .o_done      (result_done),
    .o_result    (o_result),
    .o_tag       (o_tag)
  );

  // Completion also releases the operand stage.
  assign o_done = result_done;

endmodule

// ==== testbench/tb_div_unit.sv ====
module tb_div_unit;

  localparam int DW      = div_cfg_pkg::DATA_W;
  localparam int TW      = div_cfg_pkg::TAG_W;
  localparam int LATENCY = DW + 2;

  // Request counts per test.
  localparam int N_UNSIGNED = 200;
  localparam int N_SIGNED   = 200;
  localparam int N_CROSS    = 32;
  localparam int N_ZERO     = 32;
  localparam int N_LATENCY  = 20;
  localparam int N_STALL    = 100;
  localparam int N_REQ      = N_UNSIGNED + N_SIGNED + N_CROSS + N_ZERO + N_LATENCY + N_STALL;

  // Twice the request length, plus idle tails, stall cycles and reset.
  localparam int TIMEOUT_CYCLES = N_REQ * (DW + 3) * 2 + N_LATENCY * (DW + 4)
                                  + N_STALL * (DW + 3) + 64;

  logic                  i_clk;
  logic                  i_arst_n;
  logic                  i_cg;
  logic                  i_start;
  div_op_pkg::div_op_e   i_op;
  logic [DW-1:0]         i_dividend;
  logic [DW-1:0]         i_divisor;
  logic [TW-1:0]         i_tag;
  logic                  o_busy;
  logic                  o_done;
  logic [DW-1:0]         o_result;
  logic [TW-1:0]         o_tag;

  logic [31:0]           rng_state;
  int                    cycle_cnt;
  int                    err_count;
  int                    err_mark;
  int                    req_count;
  int                    tests_passed;
  int                    tests_failed;
  string                 test_name;
  logic [DW-1:0]         special_vals [4];

  div_unit UUT (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_cg       (i_cg),
    .i_start    (i_start),
    .i_op       (i_op),
    .i_dividend (i_dividend),
    .i_divisor  (i_divisor),
    .i_tag      (i_tag),
    .o_busy     (o_busy),
    .o_done     (o_done),
    .o_result   (o_result),
    .o_tag      (o_tag)
  );

  always #10 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [15:0] rand_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  // Expected result from truncating integer division.
  function automatic logic [DW-1:0] expected_result(input div_op_pkg::div_op_e op,
                                                    input logic [DW-1:0] a,
                                                    input logic [DW-1:0] b);
    logic signed_op;
    logic rem_op;
    int   sa;
    int   sb;
    int   q;
    int   r;
    signed_op = (op == div_op_pkg::OP_DIV) || (op == div_op_pkg::OP_REM);
    rem_op    = (op == div_op_pkg::OP_REMU) || (op == div_op_pkg::OP_REM);
    if (signed_op) begin
      sa = int'($signed(a));
      sb = int'($signed(b));
    end else begin
      sa = int'(a);
      sb = int'(b);
    end
    if (sb == 0) begin
      q = -1;
      r = sa;
    end else begin
      // The overflow case yields +2**(DW-1), which wraps back to the dividend.
      q = sa / sb;
      r = sa % sb;
    end
    return rem_op ? r[DW-1:0] : q[DW-1:0];
  endfunction

  function automatic logic [DW-1:0] random_operand(input bit use_special);
    logic [15:0] r;
    r = rand_next();
    if (use_special && r[15:14] == 2'b00) begin
      return special_vals[r[1:0]];
    end
    return r[DW-1:0];
  endfunction

  function automatic logic [TW-1:0] random_tag();
    logic [15:0] r;
    r = rand_next();
    return r[TW+3:4];
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      err_count++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = err_count;
    req_count = 0;
  endtask

  task automatic report_test();
    if (err_count == err_mark) begin
      tests_passed++;
      $display("Test %s: passed, %0d requests", test_name, req_count);
    end else begin
      tests_failed++;
      $display("Test %s: failed, %0d errors in %0d requests", test_name,
               err_count - err_mark, req_count);
    end
  endtask

  // Advance one edge and report whether that edge was enabled.
  task automatic step_cycle(output logic enabled);
    enabled = i_cg;
    @(posedge i_clk);
    #2;
  endtask

  task automatic drive_cg(input bit stalls);
    logic [15:0] r;
    r = rand_next();
    i_cg = !stalls || (r[2:0] != 3'd0);
  endtask

  task automatic check_idle();
    check_value("o_busy", 32'(o_busy), 32'(0));
    check_value("o_done", 32'(o_done), 32'(0));
  endtask

  task automatic idle_cycles(input int n);
    logic en;
    i_start = 1'b0;
    i_cg    = 1'b1;
    repeat (n) begin
      step_cycle(en);
      check_idle();
    end
  endtask

  // One request from start to done, with optional stalls and a start while busy.
  task automatic run_request(input div_op_pkg::div_op_e op, input logic [DW-1:0] a,
                             input logic [DW-1:0] b, input logic [TW-1:0] tag,
                             input bit stalls, input bit extra_start);
    logic          en;
    int            en_cnt;
    logic [15:0]   r;
    logic [DW-1:0] exp_val;
    exp_val = expected_result(op, a, b);
    check_value("o_busy", 32'(o_busy), 32'(0));
    i_start    = 1'b1;
    i_op       = op;
    i_dividend = a;
    i_divisor  = b;
    i_tag      = tag;
    en = 1'b0;
    while (!en) begin
      step_cycle(en);
      drive_cg(stalls);
    end
    i_start = 1'b0;
    if (extra_start) begin
      r          = rand_next();
      i_start    = 1'b1;
      i_op       = div_op_pkg::div_op_e'(r[1:0]);
      i_dividend = r[DW+7:8];
      i_tag      = ~tag;
    end
    en_cnt = 0;
    do begin
      check_value("o_busy", 32'(o_busy), 32'(1));
      step_cycle(en);
      if (en) begin
        en_cnt++;
      end
      if (en_cnt >= 3) begin
        i_start = 1'b0;
      end
      drive_cg(stalls);
    end while (o_done !== 1'b1);
    check_value("o_done latency", 32'(en_cnt), 32'(LATENCY));
    check_value("o_busy", 32'(o_busy), 32'(0));
    check_value("o_result", 32'(o_result), 32'(exp_val));
    check_value("o_tag", 32'(o_tag), 32'(tag));
    req_count++;
  endtask

  task automatic test_reset();
    begin_test("reset state");
    repeat (4) @(posedge i_clk);
    #2;
    check_idle();
    check_value("o_result", 32'(o_result), 32'(0));
    check_value("o_tag", 32'(o_tag), 32'(0));
    repeat (4) @(posedge i_clk);
    #2;
    i_arst_n = 1'b1;
    i_cg     = 1'b1;
    repeat (3) begin
      @(posedge i_clk);
      #2;
      check_idle();
      check_value("o_result", 32'(o_result), 32'(0));
      check_value("o_tag", 32'(o_tag), 32'(0));
    end
    report_test();
  endtask

  task automatic test_unsigned();
    logic [15:0]         r;
    div_op_pkg::div_op_e op;
    begin_test("unsigned operations");
    for (int n = 0; n < N_UNSIGNED; n++) begin
      r  = rand_next();
      op = r[0] ? div_op_pkg::OP_REMU : div_op_pkg::OP_DIVU;
      run_request(op, random_operand(1'b0), random_operand(1'b0), random_tag(), 1'b0, 1'b0);
    end
    report_test();
  endtask

  task automatic test_signed();
    logic [15:0]         r;
    div_op_pkg::div_op_e op;
    begin_test("signed operations");
    for (int n = 0; n < N_SIGNED; n++) begin
      r  = rand_next();
      op = r[0] ? div_op_pkg::OP_REM : div_op_pkg::OP_DIV;
      run_request(op, random_operand(1'b1), random_operand(1'b1), random_tag(), 1'b0, 1'b0);
    end
    // Every pairing of the boundary values.
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        run_request(div_op_pkg::OP_DIV, special_vals[i], special_vals[j], random_tag(),
                    1'b0, 1'b0);
        run_request(div_op_pkg::OP_REM, special_vals[i], special_vals[j], random_tag(),
                    1'b0, 1'b0);
      end
    end
    report_test();
  endtask

  task automatic test_div_zero();
    begin_test("divide by zero");
    for (int n = 0; n < N_ZERO; n++) begin
      run_request(div_op_pkg::div_op_e'(n[1:0]), random_operand(1'b1), '0, random_tag(),
                  1'b0, 1'b0);
    end
    report_test();
  endtask

  task automatic test_latency();
    logic [15:0] r;
    begin_test("latency and busy");
    for (int n = 0; n < N_LATENCY; n++) begin
      r = rand_next();
      run_request(div_op_pkg::div_op_e'(r[1:0]), random_operand(1'b1), random_operand(1'b1),
                  random_tag(), 1'b0, 1'b1);
      // A second done here would mean the start during busy was taken.
      idle_cycles(DW + 4);
    end
    report_test();
  endtask

  task automatic test_stall();
    logic [15:0] r;
    begin_test("clock enable stalls");
    for (int n = 0; n < N_STALL; n++) begin
      r = rand_next();
      run_request(div_op_pkg::div_op_e'(r[1:0]), random_operand(1'b1), random_operand(1'b1),
                  random_tag(), 1'b1, 1'b0);
    end
    report_test();
  endtask

  initial begin
    rng_state       = 32'h91403fb2;
    err_count       = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    special_vals[0] = {1'b1, {(DW-1){1'b0}}};
    special_vals[1] = '1;
    special_vals[2] = '0;
    special_vals[3] = {1'b0, {(DW-1){1'b1}}};
    i_clk      = 1'b0;
    i_arst_n   = 1'b0;
    i_cg       = 1'b0;
    i_start    = 1'b0;
    i_op       = div_op_pkg::OP_DIVU;
    i_dividend = '0;
    i_divisor  = '0;
    i_tag      = '0;
    test_reset();
    test_unsigned();
    test_signed();
    test_div_zero();
    test_latency();
    test_stall();
    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
design/div_cfg_pkg.sv
design/div_op_pkg.sv
design/div_operand_stage.sv
design/div_core.sv
design/div_result_stage.sv
design/div_unit.sv
testbench/tb_div_unit.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = tb_div_unit
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
VFLAGS    = --binary --timing -Wno-fatal -Mdir $(OBJ_DIR) --top-module $(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	elif ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
